//--- core_stimulus.txt
# P word address, instruction; R register, expected value; S store address, data
# E expected trap, which closes a run; Q ends the file; all numbers are hex
P 00 00500093
P 01 ffd08113
P 02 123451b7
P 03 67818193
P 04 00001217
P 05 00908013
P 06 008002ef
P 07 7ff00113
P 08 02c00313
P 09 001303e7
P 0a 11100093
P 0b 00332423
P 0c fe40afa3
P 0d 00100073
P 0e 22200093
R 00 00000000
R 01 00000005
R 02 00000002
R 03 12345678
R 04 00001010
R 05 0000001c
R 06 0000002c
R 07 00000028
S 00000034 12345678
S 00000004 00001010
E 0
# second run stops on an illegal word
P 00 00700513
P 01 00a52023
P 02 ffffffff
P 03 07b00513
P 04 00a52023
R 0a 00000007
S 00000007 00000007
E 1
Q

//--- verilog.f
core_pkg.sv
core_ctrl.sv
core_pc.sv
core_ram.sv
core_regfile.sv
core_idu.sv
core_exu.sv
core_top.sv
tb_core.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" && verilator --binary --assert -f verilog.f --top-module tb_core \
	&& ./obj_dir/Vtb_core || exit 1

//--- tb_core.sv
// core testbench, loads programs from the stimulus file, runs the core and checks results
module tb_core import core_pkg::*; ();

	localparam int imem_depth  = 64;
	localparam int run_timeout = 1000;

	logic                          clk;
	logic                          rst;
	logic                          start;
	logic                          load_en;
	logic [$clog2(imem_depth)-1:0] load_addr;
	logic [xlen-1:0]               load_data;
	logic                          halted;
	logic                          trap;
	logic                          store_en;
	logic [xlen-1:0]               store_addr;
	logic [xlen-1:0]               store_data;
	logic [reg_addr_width-1:0]     dbg_raddr;
	logic [xlen-1:0]               dbg_rdata;

	// records of the run being read from the file
	logic [xlen-1:0] prog_addr [$];
	logic [xlen-1:0] prog_word [$];
	logic [xlen-1:0] reg_idx [$];
	logic [xlen-1:0] reg_val [$];
	logic [xlen-1:0] exp_st_addr [$];
	logic [xlen-1:0] exp_st_data [$];
	logic [xlen-1:0] got_st_addr [$];
	logic [xlen-1:0] got_st_data [$];

	core_top #(.data_width(xlen), .imem_depth(imem_depth), .boot_addr('0)) dut_i (
		.clk(clk), .rst(rst), .start(start), .load_en(load_en), .load_addr(load_addr),
		.load_data(load_data), .halted(halted), .trap(trap), .store_en(store_en),
		.store_addr(store_addr), .store_data(store_data), .dbg_raddr(dbg_raddr),
		.dbg_rdata(dbg_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [xlen-1:0] expected,
		input logic [xlen-1:0] actual);
		if (expected !== actual) begin
			fail_run($sformatf("error: %s expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic read_pair(input int fd, output logic [xlen-1:0] a, output logic [xlen-1:0] b);
		if ($fscanf(fd, "%h %h", a, b) != 2) fail_run("malformed record in stimulus file");
	endtask

	// one cycle of observation, stores sampled mid-cycle
	task automatic watch_cycle();
		@(negedge clk);
		if (store_en) begin
			got_st_addr.push_back(store_addr);
			got_st_data.push_back(store_data);
		end
	endtask

	task automatic run_program(input int run, input logic [xlen-1:0] exp_trap);
		int    cycles;
		string run_name;
		run_name = $sformatf("run %0d", run);
		@(posedge clk);
		rst <= 1'b1;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_value({run_name, " halted after reset"}, '0, {31'b0, halted});
		foreach (prog_addr[i]) begin
			@(posedge clk);
			load_en   <= 1'b1;
			load_addr <= prog_addr[i][$clog2(imem_depth)-1:0];
			load_data <= prog_word[i];
		end
		@(posedge clk);
		load_en <= 1'b0;
		start   <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		got_st_addr.delete();
		got_st_data.delete();
		cycles = 0;
		while (!halted) begin
			watch_cycle();
			cycles++;
			if (cycles > run_timeout) begin
				fail_run($sformatf("%s: core did not halt within %0d cycles", run_name, run_timeout));
			end
		end
		// a halted core must stay quiet
		repeat (8) watch_cycle();
		check_value({run_name, " trap"}, exp_trap, {31'b0, trap});
		foreach (reg_idx[i]) begin
			@(posedge clk);
			dbg_raddr <= reg_idx[i][reg_addr_width-1:0];
			@(negedge clk);
			check_value($sformatf("%s x%0d", run_name, reg_idx[i]), reg_val[i], dbg_rdata);
		end
		check_value({run_name, " store count"}, exp_st_addr.size(), got_st_addr.size());
		foreach (exp_st_addr[i]) begin
			check_value($sformatf("%s store %0d address", run_name, i), exp_st_addr[i],
				got_st_addr[i]);
			check_value($sformatf("%s store %0d data", run_name, i), exp_st_data[i],
				got_st_data[i]);
		end
	endtask

	initial begin
		int               fd;
		int               code;
		int               run;
		logic [7:0]       tag;
		logic [xlen-1:0]  a;
		logic [xlen-1:0]  b;
		logic [8*120-1:0] line;
		logic             done;
		rst       = 1'b1;
		start     = 1'b0;
		load_en   = 1'b0;
		load_addr = '0;
		load_data = '0;
		dbg_raddr = '0;
		run       = 0;
		done      = 1'b0;
		fd = $fopen("core_stimulus.txt", "r");
		if (fd == 0) fail_run("cannot open the stimulus file core_stimulus.txt");
		while (!done) begin
			code = $fscanf(fd, " %c", tag);
			if (code != 1) fail_run("stimulus file ends without its end marker");
			case (tag)
				"#": code = $fgets(line, fd);
				"P": begin
					read_pair(fd, a, b);
					prog_addr.push_back(a);
					prog_word.push_back(b);
				end
				"R": begin
					read_pair(fd, a, b);
					reg_idx.push_back(a);
					reg_val.push_back(b);
				end
				"S": begin
					read_pair(fd, a, b);
					exp_st_addr.push_back(a);
					exp_st_data.push_back(b);
				end
				// E closes a run and starts it
				"E": begin
					if ($fscanf(fd, "%h", a) != 1) fail_run("malformed trap record in stimulus file");
					run++;
					run_program(run, a);
					prog_addr.delete();
					prog_word.delete();
					reg_idx.delete();
					reg_val.delete();
					exp_st_addr.delete();
					exp_st_data.delete();
				end
				"Q": done = 1'b1;
				default: fail_run($sformatf("unknown record tag %c in stimulus file", tag));
			endcase
		end
		$fclose(fd);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- core_top.sv
// core top level, connects controller, pc, instruction memory, decoder and execute unit
module core_top import core_pkg::*; #(
	parameter int                    data_width = xlen,
	parameter int                    imem_depth = 64,
	parameter logic [data_width-1:0] boot_addr  = '0
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          start,
	input  logic                          load_en,
	input  logic [$clog2(imem_depth)-1:0] load_addr,
	input  logic [data_width-1:0]         load_data,
	output logic                          halted,
	output logic                          trap,
	output logic                          store_en,
	output logic [data_width-1:0]         store_addr,
	output logic [data_width-1:0]         store_data,
	input  logic [reg_addr_width-1:0]     dbg_raddr,
	output logic [data_width-1:0]         dbg_rdata
);

	localparam int imem_aw = $clog2(imem_depth);

	logic                      fetch_en;
	logic                      exec_en;
	logic                      imem_wen;
	logic [data_width-1:0]     pc;
	logic [data_width-1:0]     inst;
	decoded_t                  decoded;
	logic                      rf_wen;
	logic [reg_addr_width-1:0] rf_waddr;
	logic [data_width-1:0]     rf_wdata;
	logic                      jump_en;
	logic [data_width-1:0]     jump_target;

	// program loads land only while nothing runs
	assign imem_wen = load_en && !halted && !fetch_en && !exec_en;

	core_ctrl ctrl_i (
		.clk(clk), .rst(rst), .start(start), .decoded(decoded),
		.fetch_en(fetch_en), .exec_en(exec_en), .halted(halted), .trap(trap)
	);

	core_pc #(.data_width(data_width), .boot_addr(boot_addr)) pc_i (
		.clk(clk), .rst(rst), .exec_en(exec_en), .jump_en(jump_en),
		.jump_target(jump_target), .pc(pc)
	);

	// word address from the byte pc
	core_ram #(.data_width(data_width), .imem_depth(imem_depth)) ram_i (
		.clk(clk), .rd_en(fetch_en), .rd_addr(pc[imem_aw+1:2]),
		.wr_en(imem_wen), .wr_addr(load_addr), .wr_data(load_data), .rd_data(inst)
	);

	core_idu #(.data_width(data_width)) idu_i (
		.clk(clk), .inst(inst), .pc(pc), .rf_wen(rf_wen), .rf_waddr(rf_waddr),
		.rf_wdata(rf_wdata), .dbg_raddr(dbg_raddr), .decoded(decoded), .dbg_rdata(dbg_rdata)
	);

	core_exu #(.data_width(data_width)) exu_i (
		.pc(pc), .exec_en(exec_en), .decoded(decoded),
		.rf_wen(rf_wen), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
		.jump_en(jump_en), .jump_target(jump_target),
		.store_en(store_en), .store_addr(store_addr), .store_data(store_data)
	);

endmodule

//--- core_exu.sv
// execute unit, adder, link and jump target, register write-back and store strobe
module core_exu import core_pkg::*; #(
	parameter int data_width = xlen
) (
	input  logic [data_width-1:0]     pc,
	input  logic                      exec_en,
	input  decoded_t                  decoded,
	output logic                      rf_wen,
	output logic [reg_addr_width-1:0] rf_waddr,
	output logic [data_width-1:0]     rf_wdata,
	output logic                      jump_en,
	output logic [data_width-1:0]     jump_target,
	output logic                      store_en,
	output logic [data_width-1:0]     store_addr,
	output logic [data_width-1:0]     store_data
);

	logic [data_width-1:0] sum;
	logic [data_width-1:0] link;
	logic                  commit;

	// every supported operation is an add
	assign sum  = decoded.src1 + decoded.src2;
	assign link = pc + data_width'(4);

	assign commit = exec_en && !decoded.illegal && !decoded.is_ebreak;

	assign rf_wen   = commit && decoded.reg_wen;
	assign rf_waddr = decoded.rd;
	assign rf_wdata = decoded.is_jump ? link : sum;

	// jalr drops bit zero of the target
	assign jump_en     = commit && decoded.is_jump;
	assign jump_target = decoded.is_jalr ? {sum[data_width-1:1], 1'b0} : sum;

	assign store_en   = commit && decoded.is_store;
	assign store_addr = sum;
	assign store_data = decoded.store_data;

	// the decoder must never flag a store that also writes back
	always_comb begin
		assert (!(rf_wen && store_en))
			else $error("register write and store in one execute cycle");
	end

endmodule

//--- core_idu.sv
// instruction decoder, splits the word, builds immediates and operands, owns the register file
module core_idu import core_pkg::*; #(
	parameter int data_width = xlen
) (
	input  logic                      clk,
	input  logic [data_width-1:0]     inst,
	input  logic [data_width-1:0]     pc,
	input  logic                      rf_wen,
	input  logic [reg_addr_width-1:0] rf_waddr,
	input  logic [data_width-1:0]     rf_wdata,
	input  logic [reg_addr_width-1:0] dbg_raddr,
	output decoded_t                  decoded,
	output logic [data_width-1:0]     dbg_rdata
);

	logic [6:0]                opcode;
	logic [2:0]                funct3;
	logic [reg_addr_width-1:0] rs1;
	logic [reg_addr_width-1:0] rs2;
	logic [data_width-1:0]     imm_i;
	logic [data_width-1:0]     imm_u;
	logic [data_width-1:0]     imm_j;
	logic [data_width-1:0]     imm_s;
	logic [data_width-1:0]     imm;
	logic [data_width-1:0]     rs1_val;
	logic [data_width-1:0]     rs2_val;
	logic                      inst_addi;
	logic                      inst_lui;
	logic                      inst_auipc;
	logic                      inst_jal;
	logic                      inst_jalr;
	logic                      inst_sw;
	logic                      inst_ebreak;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];

	// instruction match, funct3 checked where the opcode is shared
	assign inst_addi   = (opcode == opc_op_imm) && (funct3 == 3'b000);
	assign inst_lui    = (opcode == opc_lui);
	assign inst_auipc  = (opcode == opc_auipc);
	assign inst_jal    = (opcode == opc_jal);
	assign inst_jalr   = (opcode == opc_jalr) && (funct3 == 3'b000);
	assign inst_sw     = (opcode == opc_store) && (funct3 == 3'b010);
	assign inst_ebreak = (inst == insn_ebreak);

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};

	always_comb begin
		imm = imm_i;
		if (inst_lui || inst_auipc) imm = imm_u;
		else if (inst_jal) imm = imm_j;
		else if (inst_sw) imm = imm_s;
	end

	core_regfile #(
		.data_width(data_width)
	) regfile_i (
		.clk      (clk),
		.raddr1   (rs1),
		.raddr2   (rs2),
		.dbg_raddr(dbg_raddr),
		.wen      (rf_wen),
		.waddr    (rf_waddr),
		.wdata    (rf_wdata),
		.rdata1   (rs1_val),
		.rdata2   (rs2_val),
		.dbg_rdata(dbg_rdata)
	);

	always_comb begin
		// pc based for jal and auipc, lui adds to zero
		if (inst_jal || inst_auipc) decoded.src1 = pc;
		else if (inst_lui) decoded.src1 = '0;
		else decoded.src1 = rs1_val;
		decoded.src2       = imm;
		decoded.store_data = rs2_val;
		decoded.rd         = inst[11:7];
		decoded.reg_wen    = !inst_sw;
		decoded.is_jump    = inst_jal || inst_jalr;
		decoded.is_jalr    = inst_jalr;
		decoded.is_store   = inst_sw;
		decoded.is_ebreak  = inst_ebreak;
		decoded.illegal    = !(inst_addi || inst_lui || inst_auipc || inst_jal ||
			inst_jalr || inst_sw || inst_ebreak);
	end

endmodule

//--- core_regfile.sv
// register file, thirty-two registers with x0 at zero, two operand ports and a debug port
module core_regfile import core_pkg::*; #(
	parameter int data_width = xlen
) (
	input  logic                      clk,
	input  logic [reg_addr_width-1:0] raddr1,
	input  logic [reg_addr_width-1:0] raddr2,
	input  logic [reg_addr_width-1:0] dbg_raddr,
	input  logic                      wen,
	input  logic [reg_addr_width-1:0] waddr,
	input  logic [data_width-1:0]     wdata,
	output logic [data_width-1:0]     rdata1,
	output logic [data_width-1:0]     rdata2,
	output logic [data_width-1:0]     dbg_rdata
);

	logic [data_width-1:0] regs [2**reg_addr_width];

	// x0 is never written
	always_ff @(posedge clk) begin
		if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// reads of x0 return zero whatever the array holds
	assign rdata1    = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2    = (raddr2 == '0) ? '0 : regs[raddr2];
	assign dbg_rdata = (dbg_raddr == '0) ? '0 : regs[dbg_raddr];

endmodule

//--- core_ram.sv
// instruction memory, word array with synchronous read and a load write port
module core_ram import core_pkg::*; #(
	parameter int data_width = xlen,
	parameter int imem_depth = 64
) (
	input  logic                          clk,
	input  logic                          rd_en,
	input  logic [$clog2(imem_depth)-1:0] rd_addr,
	input  logic                          wr_en,
	input  logic [$clog2(imem_depth)-1:0] wr_addr,
	input  logic [data_width-1:0]         wr_data,
	output logic [data_width-1:0]         rd_data
);

	logic [data_width-1:0] mem [imem_depth];

	// unwritten words decode as illegal
	initial begin
		for (int i = 0; i < imem_depth; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// read data holds until the next fetch
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

//--- core_pc.sv
// program counter, resets to the boot address and steps by four or takes a jump
module core_pc import core_pkg::*; #(
	parameter int                    data_width = xlen,
	parameter logic [data_width-1:0] boot_addr  = '0
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  exec_en,
	input  logic                  jump_en,
	input  logic [data_width-1:0] jump_target,
	output logic [data_width-1:0] pc
);

	logic [data_width-1:0] pc_next;

	// next sequential pc unless the execute unit redirects
	assign pc_next = jump_en ? jump_target : pc + data_width'(4);

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= boot_addr;
		end else if (exec_en) begin
			pc <= pc_next;
		end
	end

	// jump targets must land on a word as there is no compressed support
	assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
		else $error("pc is not word aligned: %h", pc);

endmodule

//--- core_ctrl.sv
// core controller, sequences idle, fetch, execute and halt and flags halted and trap
module core_ctrl import core_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     start,
	input  decoded_t decoded,
	output logic     fetch_en,
	output logic     exec_en,
	output logic     halted,
	output logic     trap
);

	ctrl_state_t state;
	ctrl_state_t state_next;
	logic        stop;

	assign stop = decoded.is_ebreak || decoded.illegal;

	assign fetch_en = (state == st_fetch);
	// execute only commits a legal instruction that is not ebreak
	assign exec_en = (state == st_exec) && !stop;

	always_comb begin
		state_next = state;
		case (state)
			st_idle:  if (start) state_next = st_fetch;
			st_fetch: state_next = st_exec;
			st_exec:  state_next = stop ? st_halt : st_fetch;
			default:  state_next = st_halt;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= st_idle;
			halted <= 1'b0;
			trap   <= 1'b0;
		end else begin
			state <= state_next;
			// halted and trap show up the cycle after the stopping execute
			if (state == st_exec && stop) begin
				halted <= 1'b1;
				trap   <= decoded.illegal;
			end
		end
	end

	// the instruction word is only valid in the cycle after its read
	assert property (@(posedge clk) exec_en |-> $past(fetch_en))
		else $error("execute without a fetch in the previous cycle");

	// only a reset may release the halt
	assert property (@(posedge clk) $fell(halted) |-> $past(rst))
		else $error("halted dropped without reset");

endmodule

//--- core_pkg.sv
// core package, shared widths, opcodes, decoded instruction and controller state
package core_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_width = 5;

	// major opcodes of the supported subset
	localparam logic [6:0] opc_op_imm = 7'b001_0011;
	localparam logic [6:0] opc_lui    = 7'b011_0111;
	localparam logic [6:0] opc_auipc  = 7'b001_0111;
	localparam logic [6:0] opc_jal    = 7'b110_1111;
	localparam logic [6:0] opc_jalr   = 7'b110_0111;
	localparam logic [6:0] opc_store  = 7'b010_0011;
	localparam logic [6:0] opc_system = 7'b111_0011;

	// ebreak is matched on the whole word
	localparam logic [31:0] insn_ebreak = {12'h001, 5'd0, 3'b000, 5'd0, opc_system};

	typedef enum logic [1:0] {
		st_idle  = 2'd0,
		st_fetch = 2'd1,
		st_exec  = 2'd2,
		st_halt  = 2'd3
	} ctrl_state_t;

	// decoder output, consumed by the execute unit and the controller
	typedef struct packed {
		logic [xlen-1:0]           src1;
		logic [xlen-1:0]           src2;
		// rs2 value, only meaningful for a store
		logic [xlen-1:0]           store_data;
		logic [reg_addr_width-1:0] rd;
		logic                      reg_wen;
		logic                      is_jump;
		logic                      is_jalr;
		logic                      is_store;
		logic                      is_ebreak;
		logic                      illegal;
	} decoded_t;

endpackage
